// File: src/aes_defs.svh
`ifndef AES_DEFS_SVH
`define AES_DEFS_SVH

// AES-128 only.
`define AES_NR 10

// block, key and round key width.
`define AES_BLOCK_W 128

// round constant used for round 1, doubled in GF(2^8) after every round.
`define AES_RCON_INIT 8'h01

`endif

// File: src/aes_pkg.sv
`include "aes_defs.svh"

package aes_pkg;

        typedef logic [7:0] byte_t;
        typedef logic [31:0] word_t;
        typedef logic [`AES_BLOCK_W-1:0] block_t;     // byte 0 in the top bits.
        typedef logic [$clog2(`AES_NR+1)-1:0] round_t;

        typedef struct packed {
                logic load;     // take key and plaintext.
                logic step;     // one round.
                logic last;     // final round, no MixColumns.
        } aes_ctrl_t;

        typedef enum logic {
                IDLE,
                RUN
        } ctrl_state_t;

        // multiply by x modulo x^8 + x^4 + x^3 + x + 1.
        function automatic byte_t xtime(input byte_t b);
                byte_t shifted;
                shifted = {b[6:0], 1'b0};
                return b[7] ? (shifted ^ 8'h1b) : shifted;
        endfunction

endpackage

// File: src/aes_sbox.sv
module aes_sbox
        import aes_pkg::*;
(
        input  byte_t in,
        output byte_t out
);

        byte_t inv;

        function automatic byte_t gf_mul(input byte_t a, input byte_t b);
                byte_t acc;
                byte_t x;
                acc = 8'h00;
                x = a;
                for (int i = 0; i < 8; i++)
                begin
                        if (b[i])
                                acc = acc ^ x;
                        x = xtime(x);
                end
                return acc;
        endfunction

        // a^254 is the inverse, and zero maps to zero.
        function automatic byte_t gf_inv(input byte_t a);
                byte_t sq;
                byte_t acc;
                sq = a;
                acc = 8'h01;
                for (int i = 1; i < 8; i++)
                begin
                        sq = gf_mul(sq, sq);    // a^(2^i).
                        acc = gf_mul(acc, sq);
                end
                return acc;
        endfunction

        assign inv = gf_inv(in);

        // affine map as xor of left rotations.
        assign out = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]}
                     ^ {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

endmodule

// File: src/key_expansion.sv
`include "aes_defs.svh"

module key_expansion
        import aes_pkg::*;
(
        input  logic      clk,
        input  logic      arst_n,
        input  aes_ctrl_t ctrl,
        input  block_t    key,
        output block_t    round_key
);

        block_t rk_q;
        byte_t  rcon_q;
        word_t  w0;
        word_t  w1;
        word_t  w2;
        word_t  w3;
        word_t  rot_word;
        word_t  sub_word;
        word_t  temp;
        word_t  n0;
        word_t  n1;
        word_t  n2;
        word_t  n3;

        assign {w0, w1, w2, w3} = rk_q;

        assign rot_word = {w3[23:0], w3[31:24]};        // RotWord.

        for (genvar i = 0; i < 4; i++)
        begin : g_sub_word
                aes_sbox u_sbox (
                        .in  (rot_word[8*i +: 8]),
                        .out (sub_word[8*i +: 8])
                );
        end

        assign temp = sub_word ^ {rcon_q, 24'h000000};

        // Nk = 4, so only word 0 of each round sees the sbox.
        assign n0 = w0 ^ temp;
        assign n1 = w1 ^ n0;
        assign n2 = w2 ^ n1;
        assign n3 = w3 ^ n2;

        assign round_key = {n0, n1, n2, n3};

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        rk_q   <= '0;
                        rcon_q <= `AES_RCON_INIT;
                end
                else if (ctrl.load)
                begin
                        rk_q   <= key;
                        rcon_q <= `AES_RCON_INIT;
                end
                else if (ctrl.step)
                begin
                        rk_q   <= round_key;
                        rcon_q <= xtime(rcon_q);        // 80 wraps to 1b.
                end
        end

        a_load_step_excl : assert property (@(posedge clk) disable iff (!arst_n)
                !(ctrl.load && ctrl.step));

endmodule

// File: src/aes_round_datapath.sv
`include "aes_defs.svh"

module aes_round_datapath
        import aes_pkg::*;
(
        input  logic      clk,
        input  logic      arst_n,
        input  aes_ctrl_t ctrl,
        input  block_t    plaintext,
        input  block_t    key,
        input  block_t    round_key,
        output block_t    state
);

        localparam int MSB = `AES_BLOCK_W - 1;

        block_t state_q;
        block_t sub_bytes;
        block_t shifted;
        block_t mixed;
        block_t round_out;

        // column as bytes a0..a3, row 0 on top.
        function automatic word_t mix_column(input word_t col);
                byte_t a0;
                byte_t a1;
                byte_t a2;
                byte_t a3;
                word_t res;
                {a0, a1, a2, a3} = col;
                res[31:24] = xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3;
                res[23:16] = a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3;
                res[15:8]  = a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3;
                res[7:0]   = xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3);
                return res;
        endfunction

        for (genvar b = 0; b < 16; b++)
        begin : g_sub_bytes
                aes_sbox u_sbox (
                        .in  (state_q[MSB-8*b -: 8]),
                        .out (sub_bytes[MSB-8*b -: 8])
                );
        end

        // byte index is 4*column + row.
        for (genvar c = 0; c < 4; c++)
        begin : g_col
                for (genvar r = 0; r < 4; r++)
                begin : g_row
                        assign shifted[MSB-8*(4*c+r) -: 8] =
                                sub_bytes[MSB-8*(4*((c+r)%4)+r) -: 8];
                end
                assign mixed[MSB-32*c -: 32] = mix_column(shifted[MSB-32*c -: 32]);
        end

        assign round_out = (ctrl.last ? shifted : mixed) ^ round_key;

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                        state_q <= '0;
                else if (ctrl.load)
                        state_q <= plaintext ^ key;     // initial AddRoundKey.
                else if (ctrl.step)
                        state_q <= round_out;
        end

        assign state = state_q;

        a_last_with_step : assert property (@(posedge clk) disable iff (!arst_n)
                ctrl.last |-> ctrl.step);

endmodule

// File: src/aes_control.sv
`include "aes_defs.svh"

module aes_control
        import aes_pkg::*;
(
        input  logic      clk,
        input  logic      arst_n,
        input  logic      start,
        output aes_ctrl_t ctrl,
        output logic      busy,
        output logic      done
);

        ctrl_state_t state_q;
        round_t      round_q;
        logic        done_q;
        logic        final_round;

        assign final_round = (state_q == RUN) && (round_q == round_t'(`AES_NR));

        assign ctrl.load = (state_q == IDLE) && start;  // start ignored in RUN.
        assign ctrl.step = (state_q == RUN);
        assign ctrl.last = final_round;

        always_ff @(posedge clk or negedge arst_n)
        begin
                if (!arst_n)
                begin
                        state_q <= IDLE;
                        round_q <= '0;
                        done_q  <= 1'b0;
                end
                else
                begin
                        done_q <= final_round;
                        case (state_q)
                        IDLE:
                        begin
                                if (start)
                                begin
                                        state_q <= RUN;
                                        round_q <= round_t'(1);
                                end
                        end
                        RUN:
                        begin
                                if (final_round)
                                begin
                                        state_q <= IDLE;
                                        round_q <= '0;
                                end
                                else
                                        round_q <= round_q + round_t'(1);
                        end
                        default:
                                state_q <= IDLE;
                        endcase
                end
        end

        assign busy = (state_q == RUN);
        assign done = done_q;

        a_round_range : assert property (@(posedge clk) disable iff (!arst_n)
                round_q <= round_t'(`AES_NR));

        a_done_not_busy : assert property (@(posedge clk) disable iff (!arst_n)
                !(done && busy));

endmodule

// File: src/aes_core.sv
module aes_core
        import aes_pkg::*;
(
        input  logic   clk,
        input  logic   arst_n,
        input  logic   start,
        input  block_t key,
        input  block_t plaintext,
        output block_t ciphertext,
        output logic   busy,
        output logic   done
);

        aes_ctrl_t ctrl;
        block_t    round_key;

        aes_control u_control (
                .clk    (clk),
                .arst_n (arst_n),
                .start  (start),
                .ctrl   (ctrl),
                .busy   (busy),
                .done   (done)
        );

        key_expansion u_key_expansion (
                .clk       (clk),
                .arst_n    (arst_n),
                .ctrl      (ctrl),
                .key       (key),
                .round_key (round_key)
        );

        // state register doubles as the ciphertext output.
        aes_round_datapath u_datapath (
                .clk       (clk),
                .arst_n    (arst_n),
                .ctrl      (ctrl),
                .plaintext (plaintext),
                .key       (key),
                .round_key (round_key),
                .state     (ciphertext)
        );

endmodule

// File: bench/aes_core_tb.sv
module aes_core_tb
        import aes_pkg::*;
();

        localparam int NUM_TESTS = 6;
        localparam int CLK_PERIOD = 8;

        localparam block_t C1_KEY = 128'h000102030405060708090a0b0c0d0e0f;
        localparam block_t C1_PT  = 128'h00112233445566778899aabbccddeeff;
        localparam block_t C1_CT  = 128'h69c4e0d86a7b0430d8cdb78070b4c55a;
        localparam block_t B_KEY  = 128'h2b7e151628aed2a6abf7158809cf4f3c;
        localparam block_t B_PT   = 128'h3243f6a8885a308d313198a2e0370734;
        localparam block_t B_CT   = 128'h3925841d02dc09fbdc118597196a0b32;

        logic   clk;
        logic   arst_n;
        logic   start;
        block_t key;
        block_t plaintext;
        block_t ciphertext;
        logic   busy;
        logic   done;

        int checks;
        int errors;
        int seed;

        aes_core UUT (
                .clk        (clk),
                .arst_n     (arst_n),
                .start      (start),
                .key        (key),
                .plaintext  (plaintext),
                .ciphertext (ciphertext),
                .busy       (busy),
                .done       (done)
        );

        always #(CLK_PERIOD / 2) clk = ~clk;

        task automatic check_value(input string msg, input logic [127:0] expected,
                                   input logic [127:0] actual);
                checks++;
                if (actual !== expected)
                begin
                        errors++;
                        $display("ERR %0t: %s, expected %h, got %h", $time, msg, expected, actual);
                end
        endtask

        // inputs change 1 unit after the edge.
        task automatic next_cycle();
                @(posedge clk);
                #1;
        endtask

        task automatic finish_test(input string name, input int errors_before);
                $display("%s finished with %0d errors", name, errors - errors_before);
        endtask

        // the edge inside is E0.
        task automatic start_run(input block_t k, input block_t p);
                start = 1'b1;
                key = k;
                plaintext = p;
                next_cycle();
                start = 1'b0;
                check_value("busy after start", 128'd1, 128'(busy));
        endtask

        // counts edges from E0 until done shows up.
        task automatic wait_done(input bit junk, output int edges);
                int n;
                n = 0;
                edges = 0;
                while (n < 20 && edges == 0)
                begin
                        next_cycle();
                        n++;
                        if (done)
                                edges = n;
                        else
                        begin
                                check_value("busy during run", 128'd1, 128'(busy));
                                if (junk)
                                begin
                                        start = (n < 8) && n[0];   // ignored while busy.
                                        key = {$random(seed), $random(seed),
                                               $random(seed), $random(seed)};
                                        plaintext = {$random(seed), $random(seed),
                                                     $random(seed), $random(seed)};
                                end
                        end
                end
                start = 1'b0;
                if (edges == 0)
                begin
                        errors++;
                        $display("no done pulse within 20 cycles of start at time %0t", $time);
                end
                else
                        check_value("busy in done cycle", 128'd0, 128'(busy));
        endtask

        task automatic run_vector(input block_t k, input block_t p, input block_t ct,
                                  input bit junk);
                int edges;
                start_run(k, p);
                wait_done(junk, edges);
                check_value("edges from start to done", 128'd10, 128'(edges));
                check_value("ciphertext at done", ct, ciphertext);
        endtask

        // async reset over one edge, outputs read while it is low.
        task automatic pulse_reset();
                arst_n = 1'b0;
                #2;
                check_value("busy in reset", 128'd0, 128'(busy));
                check_value("done in reset", 128'd0, 128'(done));
                check_value("ciphertext in reset", 128'd0, ciphertext);
                next_cycle();
                arst_n = 1'b1;
        endtask

        task automatic run_c1_vector();
                int e0;
                e0 = errors;
                run_vector(C1_KEY, C1_PT, C1_CT, 1'b0);
                finish_test("fips c1 vector", e0);
        endtask

        task automatic run_b_vector();
                int e0;
                e0 = errors;
                run_vector(B_KEY, B_PT, B_CT, 1'b0);
                finish_test("fips appendix b vector", e0);
        endtask

        task automatic check_timing_hold();
                int e0;
                e0 = errors;
                run_vector(C1_KEY, C1_PT, C1_CT, 1'b0);
                next_cycle();
                check_value("done after pulse", 128'd0, 128'(done));
                check_value("busy after run", 128'd0, 128'(busy));
                repeat (5)
                        next_cycle();
                check_value("ciphertext held", C1_CT, ciphertext);
                finish_test("timing and hold", e0);
        endtask

        task automatic ignore_start_while_busy();
                int e0;
                e0 = errors;
                run_vector(B_KEY, B_PT, B_CT, 1'b1);
                repeat (12)
                begin
                        next_cycle();
                        check_value("no extra done", 128'd0, 128'(done));
                end
                check_value("ciphertext after junk", B_CT, ciphertext);
                finish_test("inputs ignored while busy", e0);
        endtask

        task automatic back_to_back_runs();
                int e0;
                int edges;
                e0 = errors;
                start_run(C1_KEY, C1_PT);
                wait_done(1'b0, edges);
                check_value("first run edges", 128'd10, 128'(edges));
                check_value("first run ciphertext", C1_CT, ciphertext);
                start_run(B_KEY, B_PT);         // start held in the done cycle.
                wait_done(1'b0, edges);
                check_value("second run edges", 128'd10, 128'(edges));
                check_value("second run ciphertext", B_CT, ciphertext);
                finish_test("back-to-back runs", e0);
        endtask

        task automatic reset_mid_run();
                int e0;
                int edges;
                e0 = errors;
                start_run(B_KEY, B_PT);
                repeat (4)
                        next_cycle();
                pulse_reset();
                start_run(B_KEY, B_PT);
                wait_done(1'b0, edges);
                pulse_reset();                  // done is high here.
                run_vector(C1_KEY, C1_PT, C1_CT, 1'b0);
                finish_test("reset mid-run", e0);
        endtask

        // stops a hung run.
        initial
        begin
                #(NUM_TESTS * 40 * CLK_PERIOD);
                $display("the run timed out at time %0t", $time);
                $display("Checks failed");
                $finish;
        end

        initial
        begin
                clk = 1'b0;
                arst_n = 1'b0;
                start = 1'b0;
                key = '0;
                plaintext = '0;
                checks = 0;
                errors = 0;
                seed = 32'h643b6842;
                repeat (4)
                        next_cycle();
                arst_n = 1'b1;
                run_c1_vector();
                run_b_vector();
                check_timing_hold();
                ignore_start_while_busy();
                back_to_back_runs();
                reset_mid_run();
                $display("%0d checks, %0d errors", checks, errors);
                if (errors == 0)
                        $display("All checks passed");
                else
                        $display("Checks failed");
                $finish;
        end

endmodule

// File: aes_core.f
+incdir+src
src/aes_pkg.sv
src/aes_sbox.sv
src/key_expansion.sv
src/aes_round_datapath.sv
src/aes_control.sv
src/aes_core.sv
bench/aes_core_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -f aes_core.f --top-module aes_core_tb -o aes_core_sim || exit 1
out=$(./obj_dir/aes_core_sim)
echo "$out"
echo "$out" | grep -qx "All checks passed" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
